/* src.f */
+incdir+.
ftdi_bus_pkg.sv
order_pkg.sv
byte_fifo.sv
ftdi_port.sv
order_sorter.sv
register_file.sv
ftdi_bridge_top.sv
ftdi_bridge_props.sv
tb_ftdi_bridge.sv

/* Makefile */
# Verilator simulation of the host command bridge testbench

BIN := obj_dir/Vtb_ftdi_bridge

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): src.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --assert --top-module tb_ftdi_bridge -f src.f -o Vtb_ftdi_bridge

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_ftdi_bridge.sv */
// Testbench for the host command bridge.
// Host model on the FT245 pins, random order streams, reference register
// map, reply and fill-level checks, cycle-limit watchdog.

`timescale 1ns/1ps
`default_nettype none

`include "bridge_defines.svh"

module tb_ftdi_bridge;

    localparam int NUM_PHASES = 4;
    localparam int IDX_W      = $clog2(`REG_COUNT);

    logic                clk;
    logic                rst_n;
    logic                rxf_n;
    logic                txe_n;
    ftdi_bus_pkg::byte_t data_in;
    logic                rd_n;
    logic                oe_n;
    logic                wr_n;
    logic                data_oe;
    ftdi_bus_pkg::byte_t data_out;
    ftdi_bus_pkg::byte_t config_mode;
    ftdi_bus_pkg::byte_t work_mode;

    // host byte stream and predicted reply bytes
    ftdi_bus_pkg::byte_t host_q [$];
    ftdi_bus_pkg::byte_t reply_q [$];
    int                  phase_end [NUM_PHASES];
    int                  phase_replies [NUM_PHASES];
    ftdi_bus_pkg::byte_t phase_config [NUM_PHASES];
    ftdi_bus_pkg::byte_t phase_work [NUM_PHASES];
    int                  gen_replies;

    // reference register map
    ftdi_bus_pkg::byte_t model_store [`REG_COUNT];
    ftdi_bus_pkg::byte_t model_config;
    ftdi_bus_pkg::byte_t model_work;

    int host_idx;
    int feed_limit;
    int busy_pct;
    int got_replies;
    int cycles;
    int cycle_limit;
    int value_errors;
    int count_errors;
    int other_errors;

    ftdi_bridge_top uut (
        .clk(clk), .rst_n(rst_n),
        .rxf_n(rxf_n), .txe_n(txe_n), .data_in(data_in),
        .rd_n(rd_n), .oe_n(oe_n), .wr_n(wr_n),
        .data_oe(data_oe), .data_out(data_out),
        .config_mode(config_mode), .work_mode(work_mode)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //------------------------------
    // checks
    //------------------------------
    task automatic check_byte(string name, ftdi_bus_pkg::byte_t exp, ftdi_bus_pkg::byte_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL at %0t ns: %s expected 0x%02h actual 0x%02h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(string name, ftdi_bus_pkg::fifo_count_t exp,
                               ftdi_bus_pkg::fifo_count_t act);
        if (act !== exp) begin
            count_errors++;
            $display("FAIL at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            value_errors++;
            $display("FAIL at %0t ns: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic report_counts();
        $display("errors: value=%0d count=%0d other=%0d assertion=%0d",
                 value_errors, count_errors, other_errors, uut.port_i.props_i.fails);
    endtask

    function automatic bit rand_hit(int pct);
        return ($urandom % 100) < pct;
    endfunction

    //------------------------------
    // reference register map
    //------------------------------
    function automatic void model_write(order_pkg::reg_addr_t addr, ftdi_bus_pkg::byte_t val);
        int a;
        a = int'(addr);
        if (addr == `ADDR_CONFIG_MODE)
            model_config = val;
        else if (addr == `ADDR_WORK_MODE)
            model_work = val;
        else if (a >= int'(`REG_BASE) && a < int'(`REG_BASE) + `REG_COUNT)
            model_store[IDX_W'(a - int'(`REG_BASE))] = val;
    endfunction

    function automatic ftdi_bus_pkg::byte_t model_read(order_pkg::reg_addr_t addr);
        int a;
        a = int'(addr);
        if (addr == `ADDR_ID)
            return `BRIDGE_ID;
        if (addr == `ADDR_CONFIG_MODE)
            return model_config;
        if (addr == `ADDR_WORK_MODE)
            return model_work;
        if (a >= int'(`REG_BASE) && a < int'(`REG_BASE) + `REG_COUNT)
            return model_store[IDX_W'(a - int'(`REG_BASE))];
        return 8'h00;
    endfunction

    //------------------------------
    // order stream builders
    //------------------------------
    task automatic put_header(order_pkg::header_e hdr, order_pkg::reg_addr_t addr, int len);
        host_q.push_back(ftdi_bus_pkg::byte_t'(hdr));
        host_q.push_back(addr);
        // length goes high byte first
        host_q.push_back(ftdi_bus_pkg::byte_t'(len >> 8));
        host_q.push_back(ftdi_bus_pkg::byte_t'(len));
    endtask

    task automatic write_order(order_pkg::reg_addr_t addr, int len);
        ftdi_bus_pkg::byte_t v;
        put_header(order_pkg::ORD_WRITE, addr, len);
        for (int i = 0; i < len; i++) begin
            v = ftdi_bus_pkg::byte_t'($urandom);
            host_q.push_back(v);
            model_write(addr, v);
        end
    endtask

    task automatic read_order(order_pkg::reg_addr_t addr, int len);
        put_header(order_pkg::ORD_READ, addr, len);
        for (int i = 0; i < len; i++) begin
            reply_q.push_back(model_read(addr));
            gen_replies++;
        end
    endtask

    task automatic junk_byte();
        ftdi_bus_pkg::byte_t j;
        // anything but a known header code
        do
            j = ftdi_bus_pkg::byte_t'($urandom);
        while (j == 8'h01 || j == 8'h02);
        host_q.push_back(j);
    endtask

    function automatic order_pkg::reg_addr_t storage_addr();
        return order_pkg::reg_addr_t'(`REG_BASE + ($urandom % `REG_COUNT));
    endfunction

    function automatic order_pkg::reg_addr_t unmapped_addr();
        if ($urandom % 2)
            return order_pkg::reg_addr_t'(3 + ($urandom % 13));
        return order_pkg::reg_addr_t'(32 + ($urandom % 224));
    endfunction

    // a closing id read marks every earlier order as consumed
    task automatic end_phase(int p);
        read_order(`ADDR_ID, 1);
        phase_end[p]     = host_q.size();
        phase_replies[p] = gen_replies;
        phase_config[p]  = model_config;
        phase_work[p]    = model_work;
        gen_replies      = 0;
    endtask

    task automatic build_stimulus();
        int kind;
        // phase 0: fill every storage register and both modes
        for (int i = 0; i < `REG_COUNT; i++)
            write_order(order_pkg::reg_addr_t'(`REG_BASE + i), 1);
        write_order(`ADDR_CONFIG_MODE, 1);
        write_order(`ADDR_WORK_MODE, 1);
        end_phase(0);
        // phase 1: random mix, at most 2 replies per order
        for (int n = 0; n < 14; n++) begin
            if (rand_hit(30))
                junk_byte();
            kind = int'($urandom % 6);
            case (kind)
                0: write_order(storage_addr(), 1 + int'($urandom % 3));
                1: read_order(storage_addr(), 1 + int'($urandom % 2));
                2: begin
                    write_order(`ADDR_ID, 1);
                    read_order(`ADDR_ID, 1);
                end
                3: read_order(unmapped_addr(), 1);
                4: write_order(rand_hit(50) ? `ADDR_CONFIG_MODE : `ADDR_WORK_MODE,
                               1 + int'($urandom % 2));
                default: put_header(rand_hit(50) ? order_pkg::ORD_READ : order_pkg::ORD_WRITE,
                                    storage_addr(), 0);
            endcase
        end
        end_phase(1);
        // phase 2: read back every register after two unknown headers
        host_q.push_back(8'h00);
        host_q.push_back(8'hFF);
        for (int i = 0; i < `REG_COUNT; i++)
            read_order(order_pkg::reg_addr_t'(`REG_BASE + i), 1);
        read_order(`ADDR_CONFIG_MODE, 1);
        read_order(`ADDR_WORK_MODE, 1);
        end_phase(2);
        // phase 3: long read, run under heavy txe_n back-pressure
        read_order(storage_addr(), 28);
        end_phase(3);
    endtask

    //------------------------------
    // host model
    //------------------------------
    always @(posedge clk) begin
        int idx;
        idx = host_idx;
        if (!rd_n && !rxf_n)
            idx = idx + 1;
        host_idx <= idx;
        if (idx < feed_limit && !rand_hit(20)) begin
            rxf_n   <= 1'b0;
            data_in <= host_q[idx];
        end else begin
            rxf_n <= 1'b1;
        end
        txe_n <= rand_hit(busy_pct);
        // bus must be driven whenever a write strobe is shown
        if (!wr_n)
            check_bit("data_oe", 1'b1, data_oe);
        if (!wr_n && !txe_n) begin
            if (reply_q.size() == 0) begin
                other_errors++;
                $display("ERROR at %0t ns: reply byte 0x%02h arrived with none expected",
                         $time, data_out);
            end else begin
                check_byte("data_out", reply_q.pop_front(), data_out);
            end
            got_replies <= got_replies + 1;
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            other_errors++;
            $display("timeout: cycle limit %0d reached with %0d reply bytes still expected",
                     cycle_limit, reply_q.size());
            report_counts();
            $display("TEST FAIL");
            $finish;
        end
    end

    //------------------------------
    // main sequence
    //------------------------------
    initial begin
        int target;
        int done_before;
        void'($urandom(32'hae36));
        rst_n        = 1'b0;
        rxf_n        = 1'b1;
        txe_n        = 1'b1;
        data_in      = '0;
        host_idx     = 0;
        feed_limit   = 0;
        busy_pct     = 30;
        got_replies  = 0;
        gen_replies  = 0;
        cycles       = 0;
        cycle_limit  = 0;
        value_errors = 0;
        count_errors = 0;
        other_errors = 0;
        model_config = '0;
        model_work   = '0;
        build_stimulus();
        cycle_limit = 40 * host_q.size() + 2000;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // pins idle and modes cleared out of reset
        @(negedge clk);
        check_bit("rd_n", 1'b1, rd_n);
        check_bit("oe_n", 1'b1, oe_n);
        check_bit("wr_n", 1'b1, wr_n);
        check_bit("data_oe", 1'b0, data_oe);
        check_byte("config_mode", 8'h00, config_mode);
        check_byte("work_mode", 8'h00, work_mode);
        target = 0;
        for (int p = 0; p < NUM_PHASES; p++) begin
            @(negedge clk);
            busy_pct    = (p == NUM_PHASES - 1) ? 70 : 30;
            feed_limit  = phase_end[p];
            done_before = target;
            target      = target + phase_replies[p];
            while (got_replies < target)
                @(negedge clk);
            // wait until every byte is taken and nothing is left to send
            while (host_idx < feed_limit || !uut.rx_empty || uut.read_done ||
                   uut.sorter_i.state_q != order_pkg::IDLE || !uut.tx_empty)
                @(negedge clk);
            check_count("reply bytes", ftdi_bus_pkg::fifo_count_t'(phase_replies[p]),
                        ftdi_bus_pkg::fifo_count_t'(got_replies - done_before));
            check_byte("config_mode", phase_config[p], config_mode);
            check_byte("work_mode", phase_work[p], work_mode);
        end
        report_counts();
        if (value_errors + count_errors + other_errors + uut.port_i.props_i.fails == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* ftdi_bridge_props.sv */
// Concurrent assertions on the FT245 pin protocol, bound to ftdi_port.
// Read/write exclusion, output enable under read, bus direction.

`timescale 1ns/1ps
`default_nettype none

module ftdi_bridge_props (
    input wire clk,
    input wire rst_n,
    input wire rd_n,
    input wire oe_n,
    input wire wr_n,
    input wire data_oe
);

    // failure tally, read by the testbench
    int fails = 0;

    // never read and write the chip at once
    a_rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(!rd_n && !wr_n)
    ) else begin
        $error("rd_n and wr_n low in the same cycle");
        fails++;
    end

    a_oe_under_rd: assert property (
        @(posedge clk) disable iff (!rst_n) !rd_n |-> !oe_n
    ) else begin
        $error("rd_n low while oe_n is high");
        fails++;
    end

    // chip drives the bus while oe_n is low
    a_bus_direction: assert property (
        @(posedge clk) disable iff (!rst_n) data_oe |-> oe_n
    ) else begin
        $error("data_oe high while oe_n is low");
        fails++;
    end

endmodule

bind ftdi_port ftdi_bridge_props props_i (
    .clk(clk),
    .rst_n(rst_n),
    .rd_n(rd_n),
    .oe_n(oe_n),
    .wr_n(wr_n),
    .data_oe(data_oe)
);

`default_nettype wire

/* ftdi_bridge_top.sv */
// Host command bridge top level.
// FTDI port, receive and transmit byte FIFOs, order sorter and
// register file.

`timescale 1ns/1ps
`default_nettype none

module ftdi_bridge_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 rxf_n,
    input  wire                 txe_n,
    input  ftdi_bus_pkg::byte_t data_in,
    output logic                rd_n,
    output logic                oe_n,
    output logic                wr_n,
    output logic                data_oe,
    output ftdi_bus_pkg::byte_t data_out,
    output ftdi_bus_pkg::byte_t config_mode,
    output ftdi_bus_pkg::byte_t work_mode
);

    // host -> sorter
    logic                      rx_push;
    ftdi_bus_pkg::byte_t       rx_byte;
    logic                      rx_almost_full;
    ftdi_bus_pkg::byte_t       rx_head;
    logic                      rx_empty;
    logic                      rx_pop;

    // register file -> host
    logic                      tx_empty;
    ftdi_bus_pkg::byte_t       tx_head;
    logic                      tx_pop;
    ftdi_bus_pkg::fifo_count_t tx_count;

    // sorter -> register file
    logic                      reg_write;
    logic                      reg_read;
    order_pkg::reg_addr_t      reg_addr;
    ftdi_bus_pkg::byte_t       reg_wdata;
    logic                      read_done;
    ftdi_bus_pkg::byte_t       read_data;

    //------------------------------
    // host side
    //------------------------------
    ftdi_port port_i (
        .clk(clk), .rst_n(rst_n),
        .rxf_n(rxf_n), .txe_n(txe_n), .data_in(data_in),
        .rd_n(rd_n), .oe_n(oe_n), .wr_n(wr_n),
        .data_oe(data_oe), .data_out(data_out),
        .rx_almost_full(rx_almost_full), .rx_push(rx_push), .rx_data(rx_byte),
        .tx_empty(tx_empty), .tx_head(tx_head), .tx_pop(tx_pop)
    );

    byte_fifo rx_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(rx_push), .wr_data(rx_byte), .rd_en(rx_pop),
        .rd_data(rx_head), .empty(rx_empty), .full(),
        .almost_full(rx_almost_full), .almost_empty(), .count()
    );

    byte_fifo tx_fifo (
        .clk(clk), .rst_n(rst_n),
        .wr_en(read_done), .wr_data(read_data), .rd_en(tx_pop),
        .rd_data(tx_head), .empty(tx_empty), .full(),
        .almost_full(), .almost_empty(), .count(tx_count)
    );

    //------------------------------
    // order handling
    //------------------------------
    order_sorter sorter_i (
        .clk(clk), .rst_n(rst_n),
        .rx_data(rx_head), .rx_empty(rx_empty), .rx_rd_en(rx_pop),
        .tx_count(tx_count),
        .reg_write(reg_write), .reg_read(reg_read),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata)
    );

    register_file regs_i (
        .clk(clk), .rst_n(rst_n),
        .reg_write(reg_write), .reg_read(reg_read),
        .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .read_done(read_done), .read_data(read_data),
        .config_mode(config_mode), .work_mode(work_mode)
    );

endmodule

`default_nettype wire

/* register_file.sv */
// Bridge register map.
// Read-only identifier, two mode registers driving outputs and a bank
// of storage registers, with one-cycle reads.

`timescale 1ns/1ps
`default_nettype none

`include "bridge_defines.svh"

module register_file (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  reg_write,
    input  wire                  reg_read,
    input  order_pkg::reg_addr_t reg_addr,
    input  ftdi_bus_pkg::byte_t  reg_wdata,
    output logic                 read_done,
    output ftdi_bus_pkg::byte_t  read_data,
    output ftdi_bus_pkg::byte_t  config_mode,
    output ftdi_bus_pkg::byte_t  work_mode
);

    localparam int IDX_W = $clog2(`REG_COUNT);

    ftdi_bus_pkg::byte_t  storage [`REG_COUNT];
    order_pkg::reg_addr_t offset;
    logic                 in_storage;
    logic [IDX_W-1:0]     idx;

    // storage bank decode
    assign offset     = reg_addr - `REG_BASE;
    assign in_storage = (reg_addr >= `REG_BASE) && (offset < `REG_COUNT);
    assign idx        = offset[IDX_W-1:0];

    //------------------------------
    // mode registers
    //------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            config_mode <= '0;
            work_mode   <= '0;
            read_done   <= 1'b0;
        end else begin
            read_done <= reg_read;
            if (reg_write && reg_addr == `ADDR_CONFIG_MODE)
                config_mode <= reg_wdata;
            if (reg_write && reg_addr == `ADDR_WORK_MODE)
                work_mode <= reg_wdata;
        end
    end

    //------------------------------
    // storage and read port
    //------------------------------
    always_ff @(posedge clk) begin
        if (reg_write && in_storage)
            storage[idx] <= reg_wdata;
        if (reg_read) begin
            // id is constant, unmapped reads give zero
            if (reg_addr == `ADDR_ID)
                read_data <= `BRIDGE_ID;
            else if (reg_addr == `ADDR_CONFIG_MODE)
                read_data <= config_mode;
            else if (reg_addr == `ADDR_WORK_MODE)
                read_data <= work_mode;
            else if (in_storage)
                read_data <= storage[idx];
            else
                read_data <= 8'h00;
        end
    end

endmodule

`default_nettype wire

/* order_sorter.sv */
// Host order parser.
// Reads header, address and 16-bit length from the receive FIFO and
// issues register writes or reads, pausing reads on transmit back-pressure.

`timescale 1ns/1ps
`default_nettype none

`include "bridge_defines.svh"

module order_sorter (
    input  wire                       clk,
    input  wire                       rst_n,
    input  ftdi_bus_pkg::byte_t       rx_data,
    input  wire                       rx_empty,
    output logic                      rx_rd_en,
    input  ftdi_bus_pkg::fifo_count_t tx_count,
    output logic                      reg_write,
    output logic                      reg_read,
    output order_pkg::reg_addr_t      reg_addr,
    output ftdi_bus_pkg::byte_t       reg_wdata
);

    order_pkg::sorter_state_e state_q;
    order_pkg::reg_addr_t     addr_q;
    ftdi_bus_pkg::byte_t      len_hi_q;
    logic [15:0]              remaining_q;
    logic                     is_read_q;
    logic                     tx_stall;
    logic                     access;
    logic [15:0]              length;

    //------------------------------
    // strobes
    //------------------------------

    // read results still in flight fit in the slots above the threshold
    assign tx_stall = (tx_count >= ftdi_bus_pkg::fifo_count_t'(`TX_PROG_FULL));

    // READ is the only state that does not consume input bytes
    assign rx_rd_en  = !rx_empty && (state_q != order_pkg::READ);
    assign reg_write = (state_q == order_pkg::WRITE) && !rx_empty;
    assign reg_read  = (state_q == order_pkg::READ) && !tx_stall;
    assign reg_addr  = addr_q;
    assign reg_wdata = rx_data;

    assign access = reg_write || reg_read;
    assign length = {len_hi_q, rx_data};

    //------------------------------
    // order FSM
    //------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= order_pkg::IDLE;
            addr_q      <= '0;
            len_hi_q    <= '0;
            remaining_q <= '0;
            is_read_q   <= 1'b0;
        end else begin
            case (state_q)
                order_pkg::IDLE: begin
                    // unknown header bytes are popped and dropped
                    if (!rx_empty) begin
                        if (rx_data == order_pkg::ORD_WRITE) begin
                            is_read_q <= 1'b0;
                            state_q   <= order_pkg::ADDR;
                        end else if (rx_data == order_pkg::ORD_READ) begin
                            is_read_q <= 1'b1;
                            state_q   <= order_pkg::ADDR;
                        end
                    end
                end
                order_pkg::ADDR: begin
                    if (!rx_empty) begin
                        addr_q  <= rx_data;
                        state_q <= order_pkg::LEN_HI;
                    end
                end
                order_pkg::LEN_HI: begin
                    if (!rx_empty) begin
                        len_hi_q <= rx_data;
                        state_q  <= order_pkg::LEN_LO;
                    end
                end
                order_pkg::LEN_LO: begin
                    if (!rx_empty) begin
                        remaining_q <= length;
                        if (length == 16'd0)
                            state_q <= order_pkg::IDLE;
                        else if (is_read_q)
                            state_q <= order_pkg::READ;
                        else
                            state_q <= order_pkg::WRITE;
                    end
                end
                order_pkg::WRITE,
                order_pkg::READ: begin
                    if (access) begin
                        remaining_q <= remaining_q - 16'd1;
                        if (remaining_q == 16'd1)
                            state_q <= order_pkg::IDLE;
                    end
                end
                default: state_q <= order_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* ftdi_port.sv */
// FT245-style pin handshake.
// Moves host bytes into the receive FIFO and transmit FIFO bytes out
// to the host, with fixed read priority.

`timescale 1ns/1ps
`default_nettype none

module ftdi_port (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 rxf_n,
    input  wire                 txe_n,
    input  ftdi_bus_pkg::byte_t data_in,
    output logic                rd_n,
    output logic                oe_n,
    output logic                wr_n,
    output logic                data_oe,
    output ftdi_bus_pkg::byte_t data_out,
    input  wire                 rx_almost_full,
    output logic                rx_push,
    output ftdi_bus_pkg::byte_t rx_data,
    input  wire                 tx_empty,
    input  ftdi_bus_pkg::byte_t tx_head,
    output logic                tx_pop
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD_EN,
        ST_READ,
        ST_WRITE
    } port_state_e;

    port_state_e state_q;
    port_state_e state_d;
    logic        rd_req;
    logic        wr_req;

    // host has data and there is room to take it
    assign rd_req = !rxf_n && !rx_almost_full;
    assign wr_req = !txe_n && !tx_empty;

    //------------------------------
    // state machine
    //------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // reads win over writes
                if (rd_req)
                    state_d = ST_RD_EN;
                else if (wr_req)
                    state_d = ST_WRITE;
            end
            ST_RD_EN,
            ST_READ: begin
                state_d = rd_req ? ST_READ : ST_IDLE;
            end
            ST_WRITE: begin
                // go back through idle so a pending read gets the bus
                if (tx_empty || rd_req)
                    state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    //------------------------------
    // pins and FIFO strobes
    //------------------------------
    assign oe_n    = !(state_q == ST_RD_EN || state_q == ST_READ);
    assign rd_n    = !(state_q == ST_READ);
    // wr_n stays high once the last byte has left
    assign wr_n    = !(state_q == ST_WRITE && !tx_empty);
    assign data_oe = (state_q == ST_WRITE);
    assign data_out = tx_head;

    // a byte moves on every cycle both sides are low
    assign rx_push = !rd_n && !rxf_n;
    assign rx_data = data_in;
    assign tx_pop  = !wr_n && !txe_n;

endmodule

`default_nettype wire

/* byte_fifo.sv */
// Synchronous byte FIFO with first-word-fall-through output.
// Fill level, full/empty and almost-full/almost-empty flags.

`timescale 1ns/1ps
`default_nettype none

`include "bridge_defines.svh"

module byte_fifo (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      wr_en,
    input  ftdi_bus_pkg::byte_t      wr_data,
    input  wire                      rd_en,
    output ftdi_bus_pkg::byte_t      rd_data,
    output logic                     empty,
    output logic                     full,
    output logic                     almost_full,
    output logic                     almost_empty,
    output ftdi_bus_pkg::fifo_count_t count
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    ftdi_bus_pkg::byte_t mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic                push_ok;
    logic                pop_ok;

    // requests against a full or empty buffer are dropped
    assign push_ok = wr_en && !full;
    assign pop_ok  = rd_en && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= wr_data;
    end

    // head of queue shows without a pop
    assign rd_data = mem[rd_ptr];

    //------------------------------
    // status flags
    //------------------------------
    assign empty        = (count == '0);
    assign full         = (count == ftdi_bus_pkg::fifo_count_t'(`FIFO_DEPTH));
    assign almost_full  = (count >= ftdi_bus_pkg::fifo_count_t'(`FIFO_DEPTH - `FIFO_ALMOST_MARGIN));
    assign almost_empty = (count <= ftdi_bus_pkg::fifo_count_t'(`FIFO_ALMOST_MARGIN));

endmodule

`default_nettype wire

/* order_pkg.sv */
// Types for host orders.
// Header byte codes, the sorter FSM states and the register address.

`default_nettype none

package order_pkg;

    //------------------------------
    // order header codes
    //------------------------------

    // any other header byte is unknown and skipped
    typedef enum logic [7:0] {
        ORD_WRITE = 8'h01,
        ORD_READ  = 8'h02
    } header_e;

    //------------------------------
    // sorter FSM
    //------------------------------

    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        LEN_HI,
        LEN_LO,
        WRITE,
        READ
    } sorter_state_e;

    //------------------------------
    // register access
    //------------------------------

    typedef logic [7:0] reg_addr_t;

endpackage

`default_nettype wire

/* ftdi_bus_pkg.sv */
// Types for the host-side byte bus.
// A data byte and a FIFO fill level.

`default_nettype none

`include "bridge_defines.svh"

package ftdi_bus_pkg;

    //------------------------------
    // data path
    //------------------------------

    // one byte on the FT245 data bus or in a FIFO
    typedef logic [7:0] byte_t;

    //------------------------------
    // FIFO status
    //------------------------------

    // one extra bit so a full FIFO is representable
    typedef logic [$clog2(`FIFO_DEPTH):0] fifo_count_t;

endpackage

`default_nettype wire

/* bridge_defines.svh */
// Build-wide constants for the host command bridge.
// FIFO sizing, transmit back-pressure level, register map addresses
// and the identifier value.

`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// byte FIFOs
`define FIFO_DEPTH          16
`define FIFO_ALMOST_MARGIN  2
`define TX_PROG_FULL        12

// register map
`define ADDR_ID             8'h00
`define ADDR_CONFIG_MODE    8'h01
`define ADDR_WORK_MODE      8'h02
`define REG_BASE            8'h10
`define REG_COUNT           16
`define BRIDGE_ID           8'hA3

`endif
